// ==== common/ras_macros.svh ====
`ifndef RAS_MACROS_SVH
`define RAS_MACROS_SVH

// width of a program counter and of every stored return address
`define RAS_XLEN 32

// number of stack entries, which must be a power of two so the pointer wraps for free
`define RAS_DEPTH 16

// pointer width follows from the depth
`define RAS_PTR_W $clog2(`RAS_DEPTH)

`endif

// ==== common/ras_pkg.sv ====
package ras_pkg;

	// decode tells us which flavour of jump it resolved
	typedef enum logic {
		JUMP_JAL  = 1'b0,
		JUMP_JALR = 1'b1
	} jump_kind_e;

	// one command per cycle goes from the hint decoder to the stack
	// pop_push means pop first and then push into the slot just freed
	typedef enum logic [2:0] {
		RAS_NONE       = 3'd0,
		RAS_PUSH       = 3'd1,
		RAS_POP        = 3'd2,
		RAS_POP_PUSH   = 3'd3,
		RAS_CHECKPOINT = 3'd4,
		RAS_RESTORE    = 3'd5
	} ras_op_e;

endpackage

// ==== common/ras_update_if.sv ====
`include "ras_macros.svh"

interface ras_update_if import ras_pkg::*; ();

	// the command for this cycle, acted on at the next rising edge
	ras_op_e op;

	// return address that goes with a push or a pop_push
	// it is only looked at when op asks for a write
	logic [`RAS_XLEN-1:0] push_addr;

	// the decoder produces the command
	modport decoder (
		output op,
		output push_addr
	);

	// the stack consumes it with no handshake
	// there is no back-pressure so every command is taken
	modport stack (
		input op,
		input push_addr
	);

endinterface

// ==== source/ras_hint_decode.sv ====
`include "ras_macros.svh"

// turns the resolved jump and branch speculation strobes into a single stack command
// the register hint rules of the unprivileged ISA decide what a jump does:
//   JAL pushes only when rd is a link register
//   JALR rd not link, rs1 not link does nothing
//   JALR rd not link, rs1 link pops
//   JALR rd link, rs1 not link pushes
//   JALR both link and different pops then pushes
//   JALR both link and equal only pushes
module ras_hint_decode import ras_pkg::*; (
	input logic                 jump,
	input logic                 jalr,
	input logic [4:0]           rs1_index,
	input logic [4:0]           rd_index,
	input logic [`RAS_XLEN-1:0] jump_pc,
	input logic                 branch_checkpoint,
	input logic                 branch_restore,
	ras_update_if.decoder       upd
);

	// x1 (ra) and x5 (t0) are the two link registers
	logic rd_link;
	logic rs1_link;

	// the command that the jump alone would ask for
	ras_op_e jump_op;

	assign rd_link  = (rd_index == 5'd1) || (rd_index == 5'd5);
	assign rs1_link = (rs1_index == 5'd1) || (rs1_index == 5'd5);

	always_comb begin
		jump_op = RAS_NONE;
		if (jump) begin
			if (jalr != JUMP_JALR) begin
				// a JAL can only call, it never returns through the stack
				if (rd_link) begin
					jump_op = RAS_PUSH;
				end
			end else begin
				case ({rd_link, rs1_link})
					2'b01: jump_op = RAS_POP;
					2'b10: jump_op = RAS_PUSH;
					2'b11: begin
						// a coroutine swap when the two links differ
						// the same link on both sides is treated as a call
						if (rd_index != rs1_index) begin
							jump_op = RAS_POP_PUSH;
						end else begin
							jump_op = RAS_PUSH;
						end
					end
					default: jump_op = RAS_NONE;
				endcase
			end
		end
	end

	// restore beats checkpoint, and both beat whatever the jump wanted
	always_comb begin
		if (branch_restore) begin
			upd.op = RAS_RESTORE;
		end else if (branch_checkpoint) begin
			upd.op = RAS_CHECKPOINT;
		end else begin
			upd.op = jump_op;
		end
	end

	// the return address is the instruction after the jump
	// compressed jumps are not handled here
	assign upd.push_addr = jump_pc + `RAS_XLEN'(4);

endmodule

// ==== ras/return_address_stack.sv ====
`include "ras_macros.svh"

// circular return address stack
// the pointer always names the next free slot, so the top entry sits one below it
// an overflow wraps around and quietly overwrites the oldest entry
module return_address_stack import ras_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	ras_update_if.stack          upd,
	output logic [`RAS_XLEN-1:0] predicted_target,
	output logic                 predicted_valid
);

	// storage for the return addresses
	logic [`RAS_XLEN-1:0] entry_q [`RAS_DEPTH];

	// one valid bit per slot, cleared by a pop so that a later pop of the same slot
	// comes back invalid
	logic [`RAS_DEPTH-1:0] valid_q;

	// stack pointer and its single speculation checkpoint
	logic [`RAS_PTR_W-1:0] sp_q;
	logic [`RAS_PTR_W-1:0] sp_d;
	logic [`RAS_PTR_W-1:0] ckpt_q;

	// index of the current top entry
	logic [`RAS_PTR_W-1:0] top_idx;

	// decoded command for this cycle
	logic                  do_pop;
	logic                  do_write;
	logic [`RAS_PTR_W-1:0] write_idx;

	// wraps naturally because the depth is a power of two
	assign top_idx = sp_q - `RAS_PTR_W'(1);

	always_comb begin
		do_pop    = 1'b0;
		do_write  = 1'b0;
		write_idx = sp_q;
		sp_d      = sp_q;
		case (upd.op)
			RAS_PUSH: begin
				do_write = 1'b1;
				sp_d     = sp_q + `RAS_PTR_W'(1);
			end
			RAS_POP: begin
				do_pop = 1'b1;
				sp_d   = top_idx;
			end
			RAS_POP_PUSH: begin
				// the pop frees the top slot and the push refills it at once
				// so the pointer stays put
				do_pop    = 1'b1;
				do_write  = 1'b1;
				write_idx = top_idx;
			end
			RAS_RESTORE: begin
				sp_d = ckpt_q;
			end
			default: begin
				sp_d = sp_q;
			end
		endcase
	end

	// control state and the prediction register
	always_ff @(posedge clk) begin
		if (rst) begin
			sp_q             <= '0;
			ckpt_q           <= '0;
			valid_q          <= '0;
			predicted_valid  <= 1'b0;
			predicted_target <= '0;
		end else begin
			sp_q <= sp_d;

			// only the pointer is saved, entries overwritten under speculation stay lost
			if (upd.op == RAS_CHECKPOINT) begin
				ckpt_q <= sp_q;
			end

			// the popped entry shows up for exactly one cycle
			// an empty slot yields an invalid prediction with a zero target
			predicted_valid <= do_pop && valid_q[top_idx];
			if (do_pop && valid_q[top_idx]) begin
				predicted_target <= entry_q[top_idx];
			end else begin
				predicted_target <= '0;
			end

			if (do_pop) begin
				valid_q[top_idx] <= 1'b0;
			end
			// placed after the clear so that a pop_push leaves its slot valid
			if (do_write) begin
				valid_q[write_idx] <= 1'b1;
			end
		end
	end

	// a push or a pop_push writes its return address into the chosen slot
	always_ff @(posedge clk) begin
		if (do_write) begin
			entry_q[write_idx] <= upd.push_addr;
		end
	end

endmodule

// ==== source/ras_predictor_top.sv ====
`include "ras_macros.svh"

// return address prediction for the fetch stage
// decode feeds resolved jumps and branch speculation strobes in, and the
// predicted return target comes out one cycle after a popping jump
module ras_predictor_top import ras_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 jump,
	input  logic                 jalr,
	input  logic [4:0]           rs1_index,
	input  logic [4:0]           rd_index,
	input  logic [`RAS_XLEN-1:0] jump_pc,
	input  logic                 branch_checkpoint,
	input  logic                 branch_restore,
	output logic [`RAS_XLEN-1:0] predicted_target,
	output logic                 predicted_valid
);

	// jalr from decode read as the kind of jump
	jump_kind_e jump_kind;

	assign jump_kind = jump_kind_e'(jalr);

	// one command per cycle from the decoder into the stack
	ras_update_if upd ();

	ras_hint_decode u_decode (
		.jump              (jump),
		.jalr              (jump_kind),
		.rs1_index         (rs1_index),
		.rd_index          (rd_index),
		.jump_pc           (jump_pc),
		.branch_checkpoint (branch_checkpoint),
		.branch_restore    (branch_restore),
		.upd               (upd.decoder)
	);

	return_address_stack u_stack (
		.clk              (clk),
		.rst              (rst),
		.upd              (upd.stack),
		.predicted_target (predicted_target),
		.predicted_valid  (predicted_valid)
	);

endmodule

// ==== bench/ras_asserts.sv ====
`include "ras_macros.svh"

// checker bound into the return address stack
// it keeps its own shadow copy of the stack, driven by the same command that the
// stack sees, and compares the prediction outputs and the pointer every cycle
module ras_asserts import ras_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input ras_op_e               op,
	input logic [`RAS_XLEN-1:0]  push_addr,
	input logic [`RAS_PTR_W-1:0] sp,
	input logic [`RAS_XLEN-1:0]  predicted_target,
	input logic                  predicted_valid
);

	// number of failed assertions so far
	int unsigned error_count = 0;

	// shadow storage, one valid flag per slot just like the real stack
	logic [`RAS_XLEN-1:0] shadow_entry [`RAS_DEPTH];
	logic                 shadow_valid [`RAS_DEPTH];

	// pointers are kept as plain integers and wrapped with a modulo
	int shadow_sp;
	int shadow_ckpt;

	// what the prediction outputs should show after this edge
	logic [`RAS_XLEN-1:0] expected_target;
	logic                 expected_valid;

	// slot just below a given one on the ring
	function automatic int slot_below(input int slot);
		return (slot + `RAS_DEPTH - 1) % `RAS_DEPTH;
	endfunction

	always @(posedge clk) begin
		int top;
		top = slot_below(shadow_sp);
		if (rst) begin
			shadow_sp       <= 0;
			shadow_ckpt     <= 0;
			expected_valid  <= 1'b0;
			expected_target <= '0;
			for (int i = 0; i < `RAS_DEPTH; i++) begin
				shadow_valid[i] <= 1'b0;
			end
		end else begin
			// anything but a pop leaves the outputs idle
			expected_valid  <= 1'b0;
			expected_target <= '0;
			case (op)
				RAS_PUSH: begin
					shadow_entry[shadow_sp] <= push_addr;
					shadow_valid[shadow_sp] <= 1'b1;
					shadow_sp               <= (shadow_sp + 1) % `RAS_DEPTH;
				end
				RAS_POP: begin
					if (shadow_valid[top]) begin
						expected_valid  <= 1'b1;
						expected_target <= shadow_entry[top];
					end
					shadow_valid[top] <= 1'b0;
					shadow_sp         <= top;
				end
				RAS_POP_PUSH: begin
					// the old top is predicted, then the same slot takes the new address
					if (shadow_valid[top]) begin
						expected_valid  <= 1'b1;
						expected_target <= shadow_entry[top];
					end
					shadow_entry[top] <= push_addr;
					shadow_valid[top] <= 1'b1;
				end
				RAS_CHECKPOINT: begin
					shadow_ckpt <= shadow_sp;
				end
				RAS_RESTORE: begin
					shadow_sp <= shadow_ckpt;
				end
				default: begin
				end
			endcase
		end
	end

	// the prediction flag follows the shadow stack
	valid_matches: assert property (@(posedge clk) disable iff (rst)
		predicted_valid == expected_valid)
		else begin
			$error("** Error @%0t: predicted_valid expected %b got %b",
				$time, $sampled(expected_valid), $sampled(predicted_valid));
			error_count++;
		end

	// target must match, and be zero whenever nothing was popped
	target_matches: assert property (@(posedge clk) disable iff (rst)
		predicted_target == expected_target)
		else begin
			$error("** Error @%0t: predicted_target expected %h got %h",
				$time, $sampled(expected_target), $sampled(predicted_target));
			error_count++;
		end

	// pointer tracks the shadow pointer through wraps, checkpoints and restores
	pointer_matches: assert property (@(posedge clk) disable iff (rst)
		sp == `RAS_PTR_W'(shadow_sp))
		else begin
			$error("** Error @%0t: sp_q expected %0d got %0d",
				$time, $sampled(shadow_sp), $sampled(sp));
			error_count++;
		end

	// a pop then push in one cycle never moves the pointer
	pop_push_holds_pointer: assert property (@(posedge clk) disable iff (rst)
		op == RAS_POP_PUSH |=> sp == $past(sp))
		else begin
			$error("** Error @%0t: sp_q expected %0d got %0d",
				$time, $past(sp), $sampled(sp));
			error_count++;
		end

	// reset leaves an empty stack and no prediction
	reset_clears: assert property (@(posedge clk)
		rst |=> !predicted_valid && sp == '0)
		else begin
			$error("** Error @%0t: predicted_valid and sp_q expected 0 and 0 got %b and %0d",
				$time, $sampled(predicted_valid), $sampled(sp));
			error_count++;
		end

endmodule

bind return_address_stack ras_asserts u_ras_asserts (
	.clk              (clk),
	.rst              (rst),
	.op               (upd.op),
	.push_addr        (upd.push_addr),
	.sp               (sp_q),
	.predicted_target (predicted_target),
	.predicted_valid  (predicted_valid)
);

// ==== bench/ras_tb.sv ====
`include "ras_macros.svh"

// testbench for the return address predictor
// the stack itself is checked by the bound checker, and the command coming out of
// the hint decoder is checked here against the register hint table
module ras_tb import ras_pkg::*; ();

	// run length, used to size the timeout
	localparam int reset_cycles    = 3;
	localparam int directed_cycles = 90;
	localparam int random_cycles   = 400;
	localparam int drain_cycles    = 4;
	localparam int cycle_limit     =
		2 * (reset_cycles + directed_cycles + random_cycles + drain_cycles);

	logic                 clk;
	logic                 rst;
	logic                 jump;
	logic                 jalr;
	logic [4:0]           rs1_index;
	logic [4:0]           rd_index;
	logic [`RAS_XLEN-1:0] jump_pc;
	logic                 branch_checkpoint;
	logic                 branch_restore;
	logic [`RAS_XLEN-1:0] predicted_target;
	logic                 predicted_valid;

	// command and return address that the inputs of this cycle should produce
	ras_op_e              expected_op;
	logic [`RAS_XLEN-1:0] expected_addr;

	int unsigned check_errors = 0;
	int unsigned cycle_count = 0;
	logic [15:0] lfsr_state;

	ras_predictor_top DUT (
		.clk               (clk),
		.rst               (rst),
		.jump              (jump),
		.jalr              (jalr),
		.rs1_index         (rs1_index),
		.rd_index          (rd_index),
		.jump_pc           (jump_pc),
		.branch_checkpoint (branch_checkpoint),
		.branch_restore    (branch_restore),
		.predicted_target  (predicted_target),
		.predicted_valid   (predicted_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x1 and x5 count as link registers
	function automatic logic is_link(input logic [4:0] idx);
		return (idx == 5'd1) || (idx == 5'd5);
	endfunction

	// hint table with the speculation strobes on top
	function automatic ras_op_e command_for(input logic jmp, input logic is_jalr,
		input logic [4:0] rs1, input logic [4:0] rd, input logic ckpt, input logic rstr);
		if (rstr) return RAS_RESTORE;
		if (ckpt) return RAS_CHECKPOINT;
		if (!jmp) return RAS_NONE;
		if (!is_jalr) return is_link(rd) ? RAS_PUSH : RAS_NONE;
		if (!is_link(rd)) return is_link(rs1) ? RAS_POP : RAS_NONE;
		// rd is a link here, so a differing link in rs1 makes it a swap
		if (is_link(rs1) && (rd != rs1)) return RAS_POP_PUSH;
		return RAS_PUSH;
	endfunction

	always_comb begin
		expected_op   = command_for(jump, jalr, rs1_index, rd_index,
			branch_checkpoint, branch_restore);
		expected_addr = jump_pc + 32'd4;
	end

	command_matches: assert property (@(posedge clk) disable iff (rst)
		DUT.upd.op == expected_op)
		else begin
			$error("** Error @%0t: upd.op expected %0d got %0d",
				$time, $sampled(expected_op), $sampled(DUT.upd.op));
			check_errors++;
		end

	// the stored address is the instruction after the jump
	push_addr_matches: assert property (@(posedge clk) disable iff (rst)
		expected_op inside {RAS_PUSH, RAS_POP_PUSH} |-> DUT.upd.push_addr == expected_addr)
		else begin
			$error("** Error @%0t: upd.push_addr expected %h got %h",
				$time, $sampled(expected_addr), $sampled(DUT.upd.push_addr));
			check_errors++;
		end

	// first failure anywhere ends the run
	initial begin
		wait ((check_errors + DUT.u_stack.u_ras_asserts.error_count) != 0);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first failed check");
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout, the run went past %0d cycles", cycle_limit);
		end
	end

	// taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step for every bit handed out
	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// biased towards x0, x1 and x5 so every hint case comes up often
	function automatic logic [4:0] pick_register();
		logic [1:0] sel;
		sel = 2'(take_bits(2));
		case (sel)
			2'd0: return 5'd0;
			2'd1: return 5'd1;
			2'd2: return 5'd5;
			default: return 5'(take_bits(5));
		endcase
	endfunction

	// drives one cycle of inputs, called and returning at a falling edge
	task automatic drive_cycle(input logic jmp, input logic is_jalr, input logic [4:0] rs1,
		input logic [4:0] rd, input logic [31:0] pc, input logic ckpt, input logic rstr);
		jump              = jmp;
		jalr              = is_jalr;
		rs1_index         = rs1;
		rd_index          = rd;
		jump_pc           = pc;
		branch_checkpoint = ckpt;
		branch_restore    = rstr;
		@(negedge clk);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_cycle(1'b0, 1'b0, 5'd0, 5'd0, 32'd0, 1'b0, 1'b0);
	endtask

	task automatic call_jal(input logic [31:0] pc, input logic [4:0] rd);
		drive_cycle(1'b1, 1'b0, 5'd0, rd, pc, 1'b0, 1'b0);
	endtask

	// argument order is pc, rd, rs1
	task automatic jump_jalr(input logic [31:0] pc, input logic [4:0] rd,
		input logic [4:0] rs1);
		drive_cycle(1'b1, 1'b1, rs1, rd, pc, 1'b0, 1'b0);
	endtask

	// plain ret, that is jalr x0, 0(x1)
	task automatic return_ra(input logic [31:0] pc);
		jump_jalr(pc, 5'd0, 5'd1);
	endtask

	task automatic take_checkpoint();
		drive_cycle(1'b0, 1'b0, 5'd0, 5'd0, 32'd0, 1'b1, 1'b0);
	endtask

	task automatic restore_pointer();
		drive_cycle(1'b0, 1'b0, 5'd0, 5'd0, 32'd0, 1'b0, 1'b1);
	endtask

	// jumps and strobes freely mixed, including restore or checkpoint with a jump
	task automatic random_stream(input int count);
		logic        jmp;
		logic        is_jalr;
		logic        ckpt;
		logic        rstr;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		logic [31:0] pc;
		for (int i = 0; i < count; i++) begin
			jmp     = (take_bits(2) != 16'd0);
			is_jalr = take_bits(1) != 16'd0;
			ckpt    = (take_bits(3) == 16'd0);
			rstr    = (take_bits(4) == 16'd0);
			rs1     = pick_register();
			rd      = pick_register();
			pc      = {14'd0, take_bits(16), 2'b00};
			drive_cycle(jmp, is_jalr, rs1, rd, pc, ckpt, rstr);
		end
	endtask

	initial begin
		rst               = 1'b1;
		jump              = 1'b0;
		jalr              = 1'b0;
		rs1_index         = 5'd0;
		rd_index          = 5'd0;
		jump_pc           = '0;
		branch_checkpoint = 1'b0;
		branch_restore    = 1'b0;
		lfsr_state        = 16'd45318;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;

		// popping an empty stack predicts nothing
		idle(2);
		return_ra(32'h0000_0400);
		idle(1);

		// one call and its return, then three nested calls
		call_jal(32'h0000_1000, 5'd1);
		return_ra(32'h0000_2000);
		idle(1);
		call_jal(32'h0000_1100, 5'd1);
		call_jal(32'h0000_1200, 5'd5);
		jump_jalr(32'h0000_1300, 5'd1, 5'd0);
		return_ra(32'h0000_2100);
		jump_jalr(32'h0000_2200, 5'd0, 5'd5);
		return_ra(32'h0000_2300);
		idle(1);

		// every row of the hint table, over a marker entry
		call_jal(32'h0000_3000, 5'd1);
		call_jal(32'h0000_3010, 5'd0);
		jump_jalr(32'h0000_3020, 5'd2, 5'd6);
		jump_jalr(32'h0000_3030, 5'd5, 5'd0);
		jump_jalr(32'h0000_3040, 5'd1, 5'd5);
		jump_jalr(32'h0000_3050, 5'd5, 5'd5);
		jump_jalr(32'h0000_3060, 5'd0, 5'd1);
		repeat (3) return_ra(32'h0000_3070);
		idle(1);

		// speculative calls are undone by the restore
		call_jal(32'h0000_4000, 5'd1);
		call_jal(32'h0000_4100, 5'd1);
		take_checkpoint();
		call_jal(32'h0000_4200, 5'd1);
		call_jal(32'h0000_4300, 5'd5);
		jump_jalr(32'h0000_4400, 5'd5, 5'd1);
		restore_pointer();
		return_ra(32'h0000_4f00);
		return_ra(32'h0000_4f10);
		idle(1);

		// restore in the same cycle as a call, then checkpoint with a return
		call_jal(32'h0000_4500, 5'd1);
		take_checkpoint();
		call_jal(32'h0000_4600, 5'd1);
		drive_cycle(1'b1, 1'b0, 5'd0, 5'd1, 32'h0000_4700, 1'b0, 1'b1);
		return_ra(32'h0000_4f20);
		drive_cycle(1'b1, 1'b1, 5'd1, 5'd0, 32'h0000_4800, 1'b1, 1'b0);
		return_ra(32'h0000_4f30);
		idle(1);

		// overflow wraps over the oldest entries, extra pops find cleared slots
		for (int i = 0; i < `RAS_DEPTH + 2; i++) begin
			call_jal(32'h0000_8000 + 32'(i * 16), 5'd1);
		end
		for (int i = 0; i < `RAS_DEPTH + 4; i++) begin
			return_ra(32'h0000_9000);
		end
		idle(1);

		random_stream(random_cycles);
		idle(drain_cycles);

		if ((check_errors + DUT.u_stack.u_ras_asserts.error_count) == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "checks failed during the run");
		end
	end

endmodule

// ==== ras_predictor_top.f ====
+incdir+common
common/ras_pkg.sv
common/ras_update_if.sv
source/ras_hint_decode.sv
ras/return_address_stack.sv
source/ras_predictor_top.sv
bench/ras_asserts.sv
bench/ras_tb.sv

// ==== Bender.yml ====
package:
  name: ras_predictor

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ras_pkg.sv
      - common/ras_update_if.sv
      - source/ras_hint_decode.sv
      - ras/return_address_stack.sv
      - source/ras_predictor_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/ras_asserts.sv
      - bench/ras_tb.sv
